// ==== src/merge_settings.svh ====
`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

////////////////////
// Tuple geometry
////////////////////

`define MERGE_TUPLE_LEN 8      // Elements per tuple
`define MERGE_KEY_W 16         // Key zero marks a terminator
`define MERGE_PAYLOAD_W 16

////////////////////
// Buffering
////////////////////

`define MERGE_FIFO_DEPTH 16
`define MERGE_FIFO_SLACK 2     // Free entries at which almost-full rises

`endif

// ==== src/merge_pkg.sv ====
`default_nettype none

`include "merge_settings.svh"

package merge_pkg;

   typedef logic [`MERGE_KEY_W-1:0] key_t;

   // Key sits in the low half so element compares look at the low bits
   typedef struct packed {
      logic [`MERGE_PAYLOAD_W-1:0] payload;
      key_t                        key;
   } elem_t;

   // Element 0 holds the smallest key of a sorted tuple
   typedef elem_t [`MERGE_TUPLE_LEN-1:0] tuple_t;

endpackage

`default_nettype wire

// ==== src/tuple_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_settings.svh"

module tuple_fifo import merge_pkg::*; (
   input  wire         i_clk,
   input  wire         i_rst_n,
   input  wire tuple_t i_data,
   input  wire         i_enq,
   input  wire         i_deq,
   output tuple_t      o_data,
   output logic        o_empty,
   output logic        o_full,
   output logic        o_almost_full
);

   localparam int DEPTH = `MERGE_FIFO_DEPTH;
   localparam int SLACK = `MERGE_FIFO_SLACK;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   tuple_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   ////////////////////
   // Storage
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   assign o_data = mem[rd_ptr];   // Head is always on the output

   ////////////////////
   // Pointers and fill level
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_enq) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (i_deq) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({i_enq, i_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign o_empty       = (count == '0);
   assign o_full        = (count == CNT_W'(DEPTH));
   assign o_almost_full = ((CNT_W'(DEPTH) - count) <= CNT_W'(SLACK));

   a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_enq && o_full));

   a_no_underrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_deq && o_empty));

endmodule

`default_nettype wire

// ==== src/merge_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module merge_control import merge_pkg::*; (
   input  wire tuple_t i_a_head,
   input  wire tuple_t i_b_head,
   input  wire         i_a_empty,
   input  wire         i_b_empty,
   input  wire         i_out_almost_full,
   output logic        o_select_a,
   output logic        o_advance,
   output logic        o_finish,
   output logic        o_a_deq,
   output logic        o_b_deq
);

   key_t a_key;
   key_t b_key;
   logic a_term;
   logic b_term;

   assign a_key  = i_a_head[0].key;   // Smallest key of each head
   assign b_key  = i_b_head[0].key;
   assign a_term = (a_key == '0);
   assign b_term = (b_key == '0);

   ////////////////////
   // Selection
   ////////////////////

   always_comb begin
      if (a_term && !b_term) begin
         o_select_a = 1'b0;   // A has finished its run, drain B
      end else if (b_term && !a_term) begin
         o_select_a = 1'b1;
      end else begin
         o_select_a = (a_key <= b_key);
      end
   end

   // A step needs both heads and room for the tuple it may emit
   assign o_advance = !i_a_empty && !i_b_empty && !i_out_almost_full;
   assign o_finish  = o_advance && a_term && b_term;

   // Both terminators leave together when the run closes
   assign o_a_deq = o_advance && (o_finish || o_select_a);
   assign o_b_deq = o_advance && (o_finish || !o_select_a);

endmodule

`default_nettype wire

// ==== src/bitonic_merge_16.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_settings.svh"

module bitonic_merge_16 import merge_pkg::*; (
   input  wire tuple_t i_low_tuple,
   input  wire tuple_t i_high_tuple,
   output tuple_t      o_low_tuple,
   output tuple_t      o_high_tuple
);

   localparam int HALF   = `MERGE_TUPLE_LEN;
   localparam int N      = 2 * HALF;
   localparam int LAYERS = $clog2(N);

   elem_t net [LAYERS+1][N];   // One row per layer of the network

   genvar l;
   genvar i;

   ////////////////////
   // Bitonic input and sorted output
   ////////////////////

   generate
      for (i = 0; i < HALF; i++) begin : g_ends
         assign net[0][i]       = i_low_tuple[i];
         assign net[0][N-1-i]   = i_high_tuple[i];   // Reversed so the sequence rises then falls
         assign o_low_tuple[i]  = net[LAYERS][i];
         assign o_high_tuple[i] = net[LAYERS][HALF+i];
      end
   endgenerate

   ////////////////////
   // Half-cleaner layers
   ////////////////////

   generate
      for (l = 0; l < LAYERS; l++) begin : g_layer
         localparam int STRIDE = N >> (l + 1);
         for (i = 0; i < N; i++) begin : g_elem
            if ((i & STRIDE) == 0) begin : g_min
               assign net[l+1][i] = (net[l][i].key <= net[l][i+STRIDE].key) ?
                                    net[l][i] : net[l][i+STRIDE];
            end else begin : g_max
               assign net[l+1][i] = (net[l][i-STRIDE].key <= net[l][i].key) ?
                                    net[l][i] : net[l][i-STRIDE];
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

// ==== src/merge_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_settings.svh"

module merge_datapath import merge_pkg::*; (
   input  wire         i_clk,
   input  wire         i_rst_n,
   input  wire tuple_t i_tuple,
   input  wire         i_advance,
   input  wire         i_finish,
   output tuple_t      o_tuple,
   output logic        o_write
);

   tuple_t held_q;     // Upper eight elements seen so far
   tuple_t net_low;
   tuple_t net_high;
   logic   primed_q;

   bitonic_merge_16 i_net (
      .i_low_tuple  (held_q),
      .i_high_tuple (i_tuple),
      .o_low_tuple  (net_low),
      .o_high_tuple (net_high)
   );

   ////////////////////
   // Control state
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         primed_q <= 1'b0;
         o_write  <= 1'b0;
      end else begin
         o_write <= i_advance && primed_q;   // Only a primed step has something to emit
         if (i_advance) begin
            primed_q <= !i_finish;
         end
      end
   end

   ////////////////////
   // Held and emitted tuples
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_advance) begin
         if (i_finish) begin
            o_tuple <= held_q;   // Flush closes the run
         end else if (primed_q) begin
            o_tuple <= net_low;
            held_q  <= net_high;
         end else begin
            held_q <= i_tuple;   // First tuple of a run
         end
      end
   end

   function automatic logic keys_ascending(tuple_t t);
      logic ok;
      ok = 1'b1;
      for (int k = 1; k < `MERGE_TUPLE_LEN; k++) begin
         ok &= (t[k-1].key <= t[k].key);
      end
      return ok;
   endfunction

   a_emit_sorted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_write |-> keys_ascending(o_tuple));

endmodule

`default_nettype wire

// ==== src/tuple_merger.sv ====
`timescale 1ns/10ps
`default_nettype none

module tuple_merger import merge_pkg::*; (
   input  wire         i_clk,
   input  wire         i_rst_n,
   input  wire tuple_t i_a_tuple,
   input  wire         i_a_empty,
   output logic        o_a_read,
   input  wire tuple_t i_b_tuple,
   input  wire         i_b_empty,
   output logic        o_b_read,
   input  wire         i_out_ready,
   output logic        o_out_write,
   output tuple_t      o_out_tuple
);

   tuple_t a_head;
   tuple_t b_head;
   tuple_t sel_tuple;
   tuple_t dp_tuple;
   logic   a_empty;
   logic   b_empty;
   logic   a_full;
   logic   b_full;
   logic   out_empty;
   logic   out_almost_full;
   logic   select_a;
   logic   advance;
   logic   finish;
   logic   a_deq;
   logic   b_deq;
   logic   dp_write;
   logic   ready_q;

   ////////////////////
   // Upstream pull
   ////////////////////

   assign o_a_read = !i_a_empty && !a_full;   // Taken at the same rising edge
   assign o_b_read = !i_b_empty && !b_full;

   tuple_fifo i_fifo_a (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (i_a_tuple),
      .i_enq         (o_a_read),
      .i_deq         (a_deq),
      .o_data        (a_head),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   tuple_fifo i_fifo_b (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (i_b_tuple),
      .i_enq         (o_b_read),
      .i_deq         (b_deq),
      .o_data        (b_head),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   ////////////////////
   // Selection and merge
   ////////////////////

   merge_control i_control (
      .i_a_head          (a_head),
      .i_b_head          (b_head),
      .i_a_empty         (a_empty),
      .i_b_empty         (b_empty),
      .i_out_almost_full (out_almost_full),
      .o_select_a        (select_a),
      .o_advance         (advance),
      .o_finish          (finish),
      .o_a_deq           (a_deq),
      .o_b_deq           (b_deq)
   );

   assign sel_tuple = select_a ? a_head : b_head;

   merge_datapath i_datapath (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_tuple   (sel_tuple),
      .i_advance (advance),
      .i_finish  (finish),
      .o_tuple   (dp_tuple),
      .o_write   (dp_write)
   );

   ////////////////////
   // Downstream push
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   assign o_out_write = ready_q && !out_empty;   // Push and pop in one cycle

   tuple_fifo i_fifo_out (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (dp_tuple),
      .i_enq         (dp_write),
      .i_deq         (o_out_write),
      .o_data        (o_out_tuple),
      .o_empty       (out_empty),
      .o_full        (),
      .o_almost_full (out_almost_full)
   );

endmodule

`default_nettype wire

// ==== verif/tb_tuple_merger.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_settings.svh"

module tb_tuple_merger import merge_pkg::*; ();

   // Per test: input tuples including terminators, plus a drain allowance
   localparam int TEST_LEN = 20 + (10 + 20) + (9 + 20) + (22 + 20) + (18 + 20) + (8 + 20);
   localparam int TIMEOUT  = 4 * (16 + TEST_LEN);

   logic   i_clk;
   logic   i_rst_n;
   tuple_t i_a_tuple;
   logic   i_a_empty;
   logic   o_a_read;
   tuple_t i_b_tuple;
   logic   i_b_empty;
   logic   o_b_read;
   logic   i_out_ready;
   logic   o_out_write;
   tuple_t o_out_tuple;

   tuple_t      qa[$];          // Upstream FIFO models
   tuple_t      qb[$];
   tuple_t      out_q[$];       // Tuples seen on the output
   tuple_t      exp_q[$];
   logic        a_read_s;
   logic        b_read_s;
   logic        ready_prev;
   logic        gaps_on;
   logic        ready_random;
   logic [31:0] key_rng;
   logic [31:0] drive_rng;
   int          read_seen;
   int          write_seen;
   int          errors;
   int          checks;
   int          tests_run;
   int          cycle_cnt;

   tuple_merger i_tuple_merger (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_tuple   (i_a_tuple),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_tuple   (i_b_tuple),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_write (o_out_write),
      .o_out_tuple (o_out_tuple)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [`MERGE_PAYLOAD_W-1:0] payload_of(input key_t key);
      return `MERGE_PAYLOAD_W'(key * 16'd40503) ^ 16'h5ac3;
   endfunction

   ////////////////////
   // Clock, upstream and downstream models
   ////////////////////

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      #2;
      if (a_read_s) qa.delete(0);   // The DUT took the head at this edge
      if (b_read_s) qb.delete(0);
      drive_rng   = xorshift32(drive_rng);
      i_a_empty   = (qa.size() == 0) || (gaps_on && drive_rng[2:0] < 3);
      i_b_empty   = (qb.size() == 0) || (gaps_on && drive_rng[5:3] < 3);
      i_a_tuple   = (qa.size() != 0) ? qa[0] : '0;
      i_b_tuple   = (qb.size() != 0) ? qb[0] : '0;
      i_out_ready = ready_random ? drive_rng[8] : 1'b1;
   end

   // Outputs are sampled mid-cycle where they are settled
   always @(negedge i_clk) begin
      a_read_s = o_a_read;
      b_read_s = o_b_read;
      if (o_a_read || o_b_read) read_seen++;
      if (o_out_write) begin
         out_q.push_back(o_out_tuple);
         write_seen++;
      end
      if (i_rst_n) begin
         assert (!(o_out_write && !ready_prev)) else begin
            $display("o_out_write was high one cycle after i_out_ready was low");
            errors++;
         end
      end
      ready_prev = i_out_ready;
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the DUT stopped delivering tuples", cycle_cnt);
      $display("Something failed");
      $finish;
   end

   ////////////////////
   // Stimulus and checking helpers
   ////////////////////

   // Splits an ascending key sequence randomly over A and B, one run per side
   task automatic build_run(input int na, input int nb, input int base);
      key_t   key;
      elem_t  el;
      tuple_t ta;
      tuple_t tb_t;
      tuple_t te;
      int     rem_a;
      int     rem_b;
      int     ia;
      int     ib;
      int     ie;
      int     pick;
      key   = key_t'(base);
      rem_a = na * `MERGE_TUPLE_LEN;
      rem_b = nb * `MERGE_TUPLE_LEN;
      ia    = 0;
      ib    = 0;
      ie    = 0;
      while (rem_a + rem_b > 0) begin
         key_rng    = xorshift32(key_rng);
         key        = key + key_t'(1 + key_rng % 7);
         el.key     = key;
         el.payload = payload_of(key);
         te[ie]     = el;
         ie++;
         if (ie == `MERGE_TUPLE_LEN) begin
            exp_q.push_back(te);
            ie = 0;
         end
         key_rng = xorshift32(key_rng);
         pick    = int'(key_rng % 32'(rem_a + rem_b));
         if (pick < rem_a) begin
            ta[ia] = el;
            ia++;
            rem_a--;
            if (ia == `MERGE_TUPLE_LEN) begin
               qa.push_back(ta);
               ia = 0;
            end
         end else begin
            tb_t[ib] = el;
            ib++;
            rem_b--;
            if (ib == `MERGE_TUPLE_LEN) begin
               qb.push_back(tb_t);
               ib = 0;
            end
         end
      end
      qa.push_back('0);   // Terminators
      qb.push_back('0);
   endtask

   task automatic check_output(input string name);
      tuple_t exp_t;
      tuple_t act_t;
      int     n;
      while (out_q.size() < exp_q.size()) @(posedge i_clk);
      repeat (10) @(posedge i_clk);   // Catch any surplus tuple
      checks++;
      assert (out_q.size() == exp_q.size()) else begin
         $display("Fail %s: tuple count expected %0d actual %0d", name, exp_q.size(),
                  out_q.size());
         errors++;
      end
      checks++;
      assert (qa.size() == 0 && qb.size() == 0) else begin
         $display("Test %s left upstream tuples unread", name);
         errors++;
      end
      n = (out_q.size() < exp_q.size()) ? out_q.size() : exp_q.size();
      for (int t = 0; t < n; t++) begin
         exp_t = exp_q[t];
         act_t = out_q[t];
         for (int e = 0; e < `MERGE_TUPLE_LEN; e++) begin
            checks++;
            assert (act_t[e] == exp_t[e]) else begin
               $display("Fail %s: tuple %0d element %0d expected %h actual %h", name, t, e,
                        exp_t[e], act_t[e]);
               errors++;
            end
            assert (act_t[e].payload == payload_of(act_t[e].key)) else begin
               $display("Fail %s: payload of key %h expected %h actual %h", name,
                        act_t[e].key, payload_of(act_t[e].key), act_t[e].payload);
               errors++;
            end
         end
      end
      out_q.delete();
      exp_q.delete();
   endtask

   task automatic report_test(input string name, input int start_err);
      tests_run++;
      if (errors == start_err) begin
         $display("Test %s passed", name);
      end else begin
         $display("Test %s failed with %0d errors", name, errors - start_err);
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic run_idle();
      int start_err;
      int read_start;
      int write_start;
      start_err   = errors;
      read_start  = read_seen;
      write_start = write_seen;
      repeat (20) @(posedge i_clk);
      checks++;
      assert (read_seen == read_start && write_seen == write_start) else begin
         $display("Idle DUT raised a read or write strobe without upstream data");
         errors++;
      end
      report_test("idle", start_err);
   endtask

   task automatic run_merge(input string name, input int na, input int nb, input int base);
      int start_err;
      start_err = errors;
      build_run(na, nb, base);
      check_output(name);
      report_test(name, start_err);
   endtask

   task automatic run_backpressure();
      int start_err;
      start_err    = errors;
      ready_random = 1'b1;
      build_run(10, 10, 1);
      check_output("backpressure");
      ready_random = 1'b0;
      report_test("backpressure", start_err);
   endtask

   task automatic run_gaps();
      int start_err;
      start_err = errors;
      gaps_on   = 1'b1;
      build_run(3, 5, 500);   // Second run has lower keys, so mixing shows up
      build_run(4, 2, 1);
      check_output("gaps");
      gaps_on = 1'b0;
      report_test("gaps", start_err);
   endtask

   initial begin
      i_rst_n      = 1'b0;
      i_a_tuple    = '0;
      i_a_empty    = 1'b1;
      i_b_tuple    = '0;
      i_b_empty    = 1'b1;
      i_out_ready  = 1'b1;
      a_read_s     = 1'b0;
      b_read_s     = 1'b0;
      ready_prev   = 1'b0;
      gaps_on      = 1'b0;
      ready_random = 1'b0;
      key_rng      = 32'd15;
      drive_rng    = 32'd15;
      read_seen    = 0;
      write_seen   = 0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      repeat (16) @(posedge i_clk);
      #2 i_rst_n = 1'b1;
      @(posedge i_clk);
      run_idle();
      run_merge("interleave", 4, 4, 1);
      run_merge("unbalanced", 1, 6, 1);
      run_backpressure();
      run_gaps();
      run_merge("payload", 3, 3, 16'hf000);   // Keys near the top of the range
      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/merge_pkg.sv
src/tuple_fifo.sv
src/merge_control.sv
src/bitonic_merge_16.sv
src/merge_datapath.sv
src/tuple_merger.sv
verif/tb_tuple_merger.sv
